// ==== logic/ising_cfg_config.svh ====
/*
 * ising macro configuration path
 * sizing, derived widths and host command opcodes
 */
`ifndef ISING_CFG_CONFIG_SVH
`define ISING_CFG_CONFIG_SVH

`define ISING_NUM_SPIN      8   // spins, also array rows
`define ISING_BIT_DATA      4   // bits per weight
`define ISING_PARALLELISM   2   // J rows per memory read
`define ISING_CNT_W         16

// derived widths
`define ISING_ROW_W         (`ISING_NUM_SPIN * `ISING_BIT_DATA)
`define ISING_ROW_IDX_W     $clog2(`ISING_NUM_SPIN)
`define ISING_J_ADDR_W      ((`ISING_NUM_SPIN / `ISING_PARALLELISM > 1) ? \
                             $clog2(`ISING_NUM_SPIN / `ISING_PARALLELISM) : 1)
`define ISING_MEM_ADDR_W    $clog2(`ISING_NUM_SPIN + 2)  // J rows, h, sfc

// command opcodes
`define ISING_OP_SET_DT     4'h1
`define ISING_OP_SET_TRANS  4'h2
`define ISING_OP_CTRL       4'h3

`endif

// ==== logic/ising_cfg_pkg.sv ====
/*
 * ising config types
 * host command word, decoded settings and analog write port
 */
`default_nettype none
`include "ising_cfg_config.svh"

package ising_cfg_pkg;

    // SET_DT / SET_TRANS view
    typedef struct packed {
        logic [3:0]                 op;
        logic [27-`ISING_CNT_W:0]   rsvd;
        logic [`ISING_CNT_W-1:0]    value;
    } cfg_param_t;

    // CTRL view
    typedef struct packed {
        logic [3:0]  op;
        logic [25:0] rsvd;
        logic        enable;
        logic        start;
    } cfg_ctrl_t;

    typedef union packed {
        cfg_param_t param;
        cfg_ctrl_t  ctrl;
    } cfg_word_u;

    // write port towards the analog macro
    typedef struct packed {
        logic [`ISING_NUM_SPIN-1:0] j_wwl;    // one-hot J wordlines
        logic                       h_wwl;
        logic                       sfc_wwl;
        logic [`ISING_ROW_W-1:0]    wbl;      // write bitlines
    } macro_wr_t;

    typedef struct packed {
        logic [`ISING_CNT_W-1:0] cycles_per_write;
        logic [`ISING_CNT_W-1:0] num_trans;
        logic                    load;     // pulse, reload both counters
        logic                    enable;
        logic                    start;    // pulse
    } cfg_set_t;

endpackage

`default_nettype wire

// ==== logic/cfg_cmd_decode.sv ====
/*
 * command decode stage
 * turns host command words into counter settings, load, enable and start
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module cfg_cmd_decode (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     cmd_valid_i,
    input  ising_cfg_pkg::cfg_word_u cmd_i,
    input  logic                     idle_i,
    output ising_cfg_pkg::cfg_set_t  set_o
);
    import ising_cfg_pkg::*;

    cfg_set_t set_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            set_q <= '0;
        end else begin
            // pulses last one cycle
            set_q.load  <= 1'b0;
            set_q.start <= 1'b0;
            if (cmd_valid_i) begin
                case (cmd_i.param.op)
                    `ISING_OP_SET_DT: begin
                        set_q.cycles_per_write <= cmd_i.param.value;
                        set_q.load             <= 1'b1;
                    end
                    `ISING_OP_SET_TRANS: begin
                        set_q.num_trans <= cmd_i.param.value;
                        set_q.load      <= 1'b1;
                    end
                    `ISING_OP_CTRL: begin
                        set_q.enable <= cmd_i.ctrl.enable;
                        // start only from idle, a start during a run is dropped
                        set_q.start  <= cmd_i.ctrl.start & idle_i;
                    end
                    default: begin
                        // unknown opcode, nothing to do
                    end
                endcase
            end
        end
    end

    assign set_o = set_q;

endmodule

`default_nettype wire

// ==== logic/step_counter.sv ====
/*
 * loadable step counter
 * counts steps up to a stored limit, pulses overflow and wraps
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module step_counter #(
    parameter int unsigned CNT_W = `ISING_CNT_W
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             en_i,
    input  logic             load_i,
    input  logic [CNT_W-1:0] d_i,
    input  logic             recount_i,
    input  logic             step_i,
    output logic [CNT_W-1:0] q_o,
    output logic             overflow_o
);
    logic [CNT_W-1:0] limit_q;
    logic [CNT_W-1:0] cnt_q;
    logic             at_last;

    assign at_last    = (cnt_q == limit_q - 1'b1);
    assign overflow_o = en_i & step_i & at_last;
    assign q_o        = cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            limit_q <= '0;
            cnt_q   <= '0;
        end else begin
            if (load_i) limit_q <= d_i;
            if (!en_i || recount_i) begin
                cnt_q <= '0;
            end else if (step_i) begin
                cnt_q <= at_last ? '0 : cnt_q + 1'b1;   // wrap at limit
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/analog_cfg.sv ====
/*
 * analog configuration sequencer
 * reads J rows, then h, then sfc, and drives each one onto the macro
 * write port for a programmable number of cycles
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module analog_cfg (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    input  ising_cfg_pkg::cfg_set_t                        set_i,
    output logic                                           j_ren_o,
    output logic [`ISING_J_ADDR_W-1:0]                     j_addr_o,
    input  logic [`ISING_PARALLELISM*`ISING_ROW_W-1:0]     j_rdata_i,
    output logic                                           h_ren_o,
    output logic                                           sfc_ren_o,
    input  logic [`ISING_ROW_W-1:0]                        rdata_i,
    output ising_cfg_pkg::macro_wr_t                       macro_o,
    output logic                                           idle_o
);
    import ising_cfg_pkg::*;

    localparam int unsigned NS      = `ISING_NUM_SPIN;
    localparam int unsigned P       = `ISING_PARALLELISM;
    localparam int unsigned RW      = `ISING_ROW_W;
    localparam int unsigned CNT_W   = `ISING_CNT_W;
    localparam int unsigned SEL_W   = (P > 1) ? $clog2(P) : 1;
    localparam int unsigned H_IDX   = NS / P;
    localparam int unsigned SFC_IDX = NS / P + 1;

    logic             busy_q;
    logic             start_ok;
    logic [CNT_W-1:0] dt_limit;
    logic [CNT_W-1:0] period_q;
    logic [CNT_W-1:0] trans_q;
    logic             period_zero;
    logic             period_ovf;
    logic             trans_step;
    logic             trans_ovf;
    logic             is_h;
    logic             is_sfc;
    logic             rd_now;
    logic             j_ren_q;
    logic             h_ren_q;
    logic             sfc_ren_q;
    logic [SEL_W-1:0] sel_q;
    logic             sel_wrap;
    logic [NS-1:0]    wl_onehot;
    logic [RW-1:0]    j_row;
    macro_wr_t        macro_q;

    assign start_ok    = set_i.start & ~busy_q;
    assign dt_limit    = set_i.cycles_per_write + 1'b1;  // read slot plus wordline cycles
    assign period_zero = (period_q == '0);
    assign is_h        = (trans_q == CNT_W'(H_IDX));
    assign is_sfc      = (trans_q == CNT_W'(SFC_IDX));

    // one read per period, kind taken from the transfer count
    assign rd_now    = busy_q & set_i.enable & period_zero;
    assign j_ren_o   = rd_now & ~is_h & ~is_sfc;
    assign h_ren_o   = rd_now & is_h;
    assign sfc_ren_o = rd_now & is_sfc;
    assign j_addr_o  = trans_q[`ISING_J_ADDR_W-1:0];

    assign sel_wrap   = (sel_q == SEL_W'(P - 1));
    assign trans_step = period_ovf & (sel_wrap | is_h | is_sfc);

    assign wl_onehot = NS'(1) << (j_addr_o * P + sel_q);
    assign j_row     = j_rdata_i[sel_q*RW +: RW];   // one of the P rows read

    assign idle_o  = ~busy_q;
    assign macro_o = macro_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            j_ren_q   <= 1'b0;
            h_ren_q   <= 1'b0;
            sfc_ren_q <= 1'b0;
            sel_q     <= '0;
        end else begin
            if (!set_i.enable || trans_ovf) begin
                busy_q <= 1'b0;
            end else if (start_ok) begin
                busy_q <= 1'b1;
            end
            j_ren_q   <= j_ren_o;   // data arrives with these
            h_ren_q   <= h_ren_o;
            sfc_ren_q <= sfc_ren_o;
            if (start_ok || !set_i.enable) begin
                sel_q <= '0;
            end else if (period_ovf && !is_h && !is_sfc) begin
                sel_q <= sel_wrap ? '0 : sel_q + 1'b1;
            end
        end
    end

    // write port, wordline period ends on the next read slot
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            macro_q <= '0;
        end else begin
            if (!set_i.enable || period_zero) begin
                macro_q.j_wwl   <= '0;
                macro_q.h_wwl   <= 1'b0;
                macro_q.sfc_wwl <= 1'b0;
            end else if (busy_q) begin
                if (j_ren_q) macro_q.j_wwl <= wl_onehot;
                if (h_ren_q) macro_q.h_wwl <= 1'b1;
                if (sfc_ren_q) macro_q.sfc_wwl <= 1'b1;
            end
            if (j_ren_q) begin
                macro_q.wbl <= j_row;
            end else if (h_ren_q || sfc_ren_q) begin
                macro_q.wbl <= rdata_i;
            end
        end
    end

    step_counter #(
        .CNT_W (CNT_W)
    ) u_step_counter_dt_write (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (set_i.enable),
        .load_i     (set_i.load),
        .d_i        (dt_limit),
        .recount_i  (start_ok),
        .step_i     (busy_q),
        .q_o        (period_q),
        .overflow_o (period_ovf)
    );

    step_counter #(
        .CNT_W (CNT_W)
    ) u_step_counter_trans (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (set_i.enable),
        .load_i     (set_i.load),
        .d_i        (set_i.num_trans),
        .recount_i  (start_ok),
        .step_i     (trans_step),
        .q_o        (trans_q),
        .overflow_o (trans_ovf)
    );

endmodule

`default_nettype wire

// ==== logic/cfg_data_mem.sv ====
/*
 * staging memory for J rows, h and sfc
 * host write port, read port answers one cycle after its enable
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module cfg_data_mem (
    input  logic                                       clk_i,
    input  logic                                       mem_we_i,
    input  logic [`ISING_MEM_ADDR_W-1:0]               mem_addr_i,
    input  logic [`ISING_ROW_W-1:0]                    mem_wdata_i,
    input  logic                                       j_ren_i,
    input  logic [`ISING_J_ADDR_W-1:0]                 j_addr_i,
    input  logic                                       h_ren_i,
    input  logic                                       sfc_ren_i,
    output logic [`ISING_PARALLELISM*`ISING_ROW_W-1:0] j_rdata_o,
    output logic [`ISING_ROW_W-1:0]                    rdata_o
);
    localparam int unsigned NS    = `ISING_NUM_SPIN;
    localparam int unsigned P     = `ISING_PARALLELISM;
    localparam int unsigned RW    = `ISING_ROW_W;
    localparam int unsigned IDX_W = `ISING_ROW_IDX_W;

    logic [RW-1:0] j_mem [NS];
    logic [RW-1:0] h_q;
    logic [RW-1:0] sfc_q;

    // host side
    always_ff @(posedge clk_i) begin
        if (mem_we_i) begin
            if (mem_addr_i < NS) begin
                j_mem[mem_addr_i[IDX_W-1:0]] <= mem_wdata_i;
            end else if (mem_addr_i == NS) begin
                h_q <= mem_wdata_i;
            end else if (mem_addr_i == NS + 1) begin
                sfc_q <= mem_wdata_i;
            end
        end
    end

    // sequencer side, P consecutive rows per J read
    always_ff @(posedge clk_i) begin
        if (j_ren_i) begin
            for (int k = 0; k < P; k++) begin
                j_rdata_o[k*RW +: RW] <= j_mem[j_addr_i*P + k];
            end
        end
        if (h_ren_i) begin
            rdata_o <= h_q;
        end else if (sfc_ren_i) begin
            rdata_o <= sfc_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/analog_shadow_array.sv ====
/*
 * shadow of the analog array contents
 * latches bitlines under each wordline, readback uses the memory map
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module analog_shadow_array (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  ising_cfg_pkg::macro_wr_t      macro_i,
    input  logic [`ISING_MEM_ADDR_W-1:0]  rd_addr_i,
    output logic [`ISING_ROW_W-1:0]       rd_data_o
);
    localparam int unsigned NS    = `ISING_NUM_SPIN;
    localparam int unsigned RW    = `ISING_ROW_W;
    localparam int unsigned IDX_W = `ISING_ROW_IDX_W;

    logic [RW-1:0] j_row_q [NS];
    logic [RW-1:0] h_row_q;
    logic [RW-1:0] sfc_row_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NS; i++) begin
                j_row_q[i] <= '0;
            end
            h_row_q   <= '0;
            sfc_row_q <= '0;
        end else begin
            for (int i = 0; i < NS; i++) begin
                if (macro_i.j_wwl[i]) j_row_q[i] <= macro_i.wbl;  // every cycle the line is up
            end
            if (macro_i.h_wwl) h_row_q <= macro_i.wbl;
            if (macro_i.sfc_wwl) sfc_row_q <= macro_i.wbl;
        end
    end

    always_comb begin
        rd_data_o = '0;   // unmapped addresses read zero
        if (rd_addr_i < NS) begin
            rd_data_o = j_row_q[rd_addr_i[IDX_W-1:0]];
        end else if (rd_addr_i == NS) begin
            rd_data_o = h_row_q;
        end else if (rd_addr_i == NS + 1) begin
            rd_data_o = sfc_row_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ising_cfg_top.sv ====
/*
 * ising configuration path top
 * command decode, staging memory, sequencer and shadow array
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module ising_cfg_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          cmd_valid_i,
    input  ising_cfg_pkg::cfg_word_u      cmd_i,
    input  logic                          mem_we_i,
    input  logic [`ISING_MEM_ADDR_W-1:0]  mem_addr_i,
    input  logic [`ISING_ROW_W-1:0]       mem_wdata_i,
    input  logic [`ISING_MEM_ADDR_W-1:0]  rd_addr_i,
    output logic [`ISING_ROW_W-1:0]       rd_data_o,
    output ising_cfg_pkg::macro_wr_t      macro_o,
    output logic                          idle_o
);
    import ising_cfg_pkg::*;

    cfg_set_t                                   cfg_set;
    logic                                       j_ren;
    logic [`ISING_J_ADDR_W-1:0]                 j_addr;
    logic                                       h_ren;
    logic                                       sfc_ren;
    logic [`ISING_PARALLELISM*`ISING_ROW_W-1:0] j_rdata;
    logic [`ISING_ROW_W-1:0]                    rdata;   // h or sfc

    cfg_cmd_decode u_cfg_cmd_decode (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .idle_i      (idle_o),
        .set_o       (cfg_set)
    );

    cfg_data_mem u_cfg_data_mem (
        .clk_i       (clk_i),
        .mem_we_i    (mem_we_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .j_ren_i     (j_ren),
        .j_addr_i    (j_addr),
        .h_ren_i     (h_ren),
        .sfc_ren_i   (sfc_ren),
        .j_rdata_o   (j_rdata),
        .rdata_o     (rdata)
    );

    analog_cfg u_analog_cfg (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .set_i     (cfg_set),
        .j_ren_o   (j_ren),
        .j_addr_o  (j_addr),
        .j_rdata_i (j_rdata),
        .h_ren_o   (h_ren),
        .sfc_ren_o (sfc_ren),
        .rdata_i   (rdata),
        .macro_o   (macro_o),
        .idle_o    (idle_o)
    );

    analog_shadow_array u_analog_shadow_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .macro_i   (macro_o),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/ising_cfg_tb.sv ====
/*
 * testbench for the ising configuration path
 * trace driven programming runs, wordline monitor and readback checks
 */
`timescale 1ns/1ps
`default_nettype none
`include "ising_cfg_config.svh"

module ising_cfg_tb;
    import ising_cfg_pkg::*;

    localparam int NS           = `ISING_NUM_SPIN;
    localparam int RW           = `ISING_ROW_W;
    localparam int AW           = `ISING_MEM_ADDR_W;
    localparam int PERIOD       = 20;
    localparam int RAND_CPW_MAX = 6;
    localparam int RUNS         = 4;   // full run, cut run, rerun, busy start run

    logic          clk_i;
    logic          rst_i;
    logic          cmd_valid_i;
    cfg_word_u     cmd_i;
    logic          mem_we_i;
    logic [AW-1:0] mem_addr_i;
    logic [RW-1:0] mem_wdata_i;
    logic [AW-1:0] rd_addr_i;
    logic [RW-1:0] rd_data_o;
    macro_wr_t     macro_o;
    logic          idle_o;

    logic [RW-1:0] trace_rows [NS+2];
    logic [RW-1:0] mem_img    [NS+2];   // staging memory as written
    logic [RW-1:0] exp_rows   [NS+2];
    int            trace_cpw;
    int            trace_trans;
    bit            trace_loaded;
    int            val_err;
    int            timing_err;
    int            order_err;
    int            tests_run;
    int            tests_failed;

    // wordline monitor state
    bit            mon_en;
    int            cpw_exp;
    int            pulse_cnt;
    int            run_len;
    int            prev_idx;
    int            idle_rises;
    logic          prev_idle;

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    ising_cfg_top uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .mem_we_i    (mem_we_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .macro_o     (macro_o),
        .idle_o      (idle_o)
    );

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, inout int cnt);
        assert (got === exp) else begin
            $display("ERROR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
            cnt++;
        end
    endtask

    task automatic send_word(input cfg_word_u w);
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_i       <= w;
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
    endtask

    task automatic set_param(input logic [3:0] op, input int value);
        cfg_word_u w;
        w             = '0;
        w.param.op    = op;
        w.param.value = value[`ISING_CNT_W-1:0];
        send_word(w);
    endtask

    task automatic ctrl_cmd(input bit enable, input bit start);
        cfg_word_u w;
        w             = '0;
        w.ctrl.op     = `ISING_OP_CTRL;
        w.ctrl.enable = enable;
        w.ctrl.start  = start;
        send_word(w);
    endtask

    task automatic write_row(input int addr, input logic [RW-1:0] data);
        @(posedge clk_i);
        mem_we_i    <= 1'b1;
        mem_addr_i  <= AW'(addr);
        mem_wdata_i <= data;
        @(posedge clk_i);
        mem_we_i     <= 1'b0;
        mem_img[addr] = data;
    endtask

    task automatic check_readback(input bit zero, inout int cnt);
        for (int a = 0; a < NS + 2; a++) begin
            @(posedge clk_i);
            rd_addr_i <= AW'(a);
            @(negedge clk_i);
            check_value($sformatf("rd_data_o[%0d]", a), rd_data_o,
                        zero ? '0 : exp_rows[a], cnt);
        end
    endtask

    // start pulse, then idle_o must drop within a few cycles
    task automatic start_run(inout int cnt);
        int n;
        n = 0;
        ctrl_cmd(1'b1, 1'b1);
        @(negedge clk_i);
        while (idle_o && n < 4) begin
            @(negedge clk_i);
            n++;
        end
        assert (!idle_o) else begin
            $display("run did not start, idle_o still high at %0t", $time);
            cnt++;
        end
    endtask

    task automatic wait_done(input int cpw, inout int cnt);
        int n;
        n = 0;
        while (!idle_o && n < (NS + 2) * (cpw + 2) + 50) begin
            @(negedge clk_i);
            n++;
        end
        assert (idle_o) else begin
            $display("run did not end within %0d cycles at %0t", n, $time);
            cnt++;
        end
        repeat (2) @(posedge clk_i);   // last wordline drops one cycle after idle
    endtask

    task automatic monitor_start(input int cpw);
        cpw_exp    = cpw;
        pulse_cnt  = 0;
        run_len    = 0;
        prev_idx   = -1;
        idle_rises = 0;
        mon_en     = 1'b1;
    endtask

    task automatic end_test(input int num, input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", num, name, errs);
        end
    endtask

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         kind;
        logic [63:0] f1;
        logic [63:0] f2;
        ok = 1'b0;
        fd = $fopen("sim/ising_cfg_trace.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", kind, f1, f2);
                if (n == 3 && kind == "W" && f1 < NS + 2) trace_rows[int'(f1)] = f2;
                if (n == 3 && kind == "E" && f1 < NS + 2) exp_rows[int'(f1)] = f2;
                if (n == 3 && kind == "S") begin
                    trace_cpw   = int'(f1);
                    trace_trans = int'(f2);
                    ok          = 1'b1;   // settings line is mandatory
                end
            end
            $fclose(fd);
        end
    endtask

    // one wordline at a time, pulse length, bitline data and write order
    always @(negedge clk_i) begin : wl_monitor
        logic [NS+1:0] lines;
        int            cur;
        lines = {macro_o.sfc_wwl, macro_o.h_wwl, macro_o.j_wwl};
        cur   = -1;
        for (int i = 0; i < NS + 2; i++) begin
            if (lines[i]) cur = i;
        end
        if (mon_en) begin
            assert ($countones(lines) <= 1) else begin
                $display("more than one wordline high at %0t, lines %b", $time, lines);
                timing_err++;
            end
            if (cur >= 0) check_value("macro_o.wbl", macro_o.wbl, mem_img[cur], timing_err);
            if (cur != prev_idx) begin
                if (prev_idx >= 0) begin
                    check_value($sformatf("wordline %0d pulse length", prev_idx),
                                run_len, cpw_exp, timing_err);
                    check_value("wordline order index", prev_idx, pulse_cnt, order_err);
                    pulse_cnt++;
                end
                run_len = 1;
            end else if (cur >= 0) begin
                run_len++;
            end
            prev_idx = cur;
            if (idle_o && !prev_idle) idle_rises++;
        end
        prev_idle = idle_o;
    end

    initial begin : watchdog
        longint limit;
        int     cpw_max;
        wait (trace_loaded);
        cpw_max = (trace_cpw > RAND_CPW_MAX) ? trace_cpw : RAND_CPW_MAX;
        limit   = longint'(RUNS) * (NS + 2) * (cpw_max + 2) + 1000;   // plus load and readback
        #(limit * PERIOD);
        $display("timeout, simulation ran past %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int            e0;
        int            t0;
        int            o0;
        int            cpw2;
        bit            ok;
        logic [RW-1:0] r;
        rst_i        = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        mem_we_i     = 1'b0;
        mem_addr_i   = '0;
        mem_wdata_i  = '0;
        rd_addr_i    = '0;
        mon_en       = 1'b0;
        prev_idle    = 1'b1;
        val_err      = 0;
        timing_err   = 0;
        order_err    = 0;
        tests_run    = 0;
        tests_failed = 0;
        r = $urandom(32'h573e_b705);   // seeds the generator
        load_trace(ok);
        trace_loaded = ok;
        assert (ok) else begin
            $display("trace file sim/ising_cfg_trace.txt missing or without settings line");
            val_err++;
        end
        if (ok) begin
            repeat (8) @(posedge clk_i);
            rst_i <= 1'b0;

            e0 = val_err;
            @(negedge clk_i);
            check_value("idle_o", idle_o, 1, val_err);
            check_value("macro_o", macro_o, 0, val_err);
            check_readback(1'b1, val_err);
            end_test(1, "reset state", val_err - e0);

            e0 = val_err;
            for (int a = 0; a < NS + 2; a++) write_row(a, trace_rows[a]);
            set_param(`ISING_OP_SET_DT, trace_cpw);
            set_param(`ISING_OP_SET_TRANS, trace_trans);
            monitor_start(trace_cpw);
            start_run(val_err);
            wait_done(trace_cpw, val_err);
            mon_en = 1'b0;
            check_readback(1'b0, val_err);
            end_test(2, "full programming run", val_err - e0);
            end_test(3, "wordline timing", timing_err);
            e0 = val_err;
            check_value("write period count", pulse_cnt, NS + 2, val_err);
            end_test(4, "write order", order_err + val_err - e0);

            e0 = val_err;
            t0 = timing_err;
            o0 = order_err;
            start_run(val_err);
            repeat (3 * (trace_cpw + 1) + 2) @(posedge clk_i);
            @(negedge clk_i);
            check_value("idle_o before disable", idle_o, 0, val_err);
            ctrl_cmd(1'b0, 1'b0);
            @(posedge clk_i);
            @(negedge clk_i);
            check_value("macro_o wordlines after disable",
                        {macro_o.j_wwl, macro_o.h_wwl, macro_o.sfc_wwl}, 0, val_err);
            check_value("idle_o after disable", idle_o, 1, val_err);
            for (int a = 0; a < NS + 2; a++) begin
                r           = RW'($urandom());
                exp_rows[a] = r;
                write_row(a, r);
            end
            cpw2 = 3 + int'($urandom() % (RAND_CPW_MAX - 2));   // 3 to 6
            set_param(`ISING_OP_SET_DT, cpw2);
            monitor_start(cpw2);
            start_run(val_err);
            wait_done(cpw2, val_err);
            mon_en = 1'b0;
            check_readback(1'b0, val_err);
            check_value("write period count", pulse_cnt, NS + 2, val_err);
            end_test(5, "disable and rerun", val_err - e0 + timing_err - t0 + order_err - o0);

            e0 = val_err;
            t0 = timing_err;
            o0 = order_err;
            monitor_start(cpw2);
            start_run(val_err);
            repeat (2 * (cpw2 + 1) + 1) @(posedge clk_i);
            ctrl_cmd(1'b1, 1'b1);   // second start while busy
            wait_done(cpw2, val_err);
            repeat (3 * (cpw2 + 1)) @(posedge clk_i);
            mon_en = 1'b0;
            @(negedge clk_i);
            check_value("idle_o after run", idle_o, 1, val_err);
            check_value("idle_o rise count", idle_rises, 1, val_err);
            check_value("write period count", pulse_cnt, NS + 2, val_err);
            end_test(6, "start while busy", val_err - e0 + timing_err - t0 + order_err - o0);
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed,
                 val_err + timing_err + order_err);
        if (tests_failed == 0 && val_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ising_cfg_trace.txt ====
# W addr data = staging memory write, S cpw trans = cycles per write and transfers
# E addr data = expected readback row after the run, all fields hex
W 0 1a2b3c4d
W 1 2468ace0
W 2 13579bdf
W 3 f0e1d2c3
W 4 5a5a0ff0
W 5 7c3e91a4
W 6 e4d2c6b8
W 7 31415926
W 8 00ff7711
W 9 8c8c4242
S 4 6
E 0 1a2b3c4d
E 1 2468ace0
E 2 13579bdf
E 3 f0e1d2c3
E 4 5a5a0ff0
E 5 7c3e91a4
E 6 e4d2c6b8
E 7 31415926
E 8 00ff7711
E 9 8c8c4242

// ==== ising_cfg_top.f ====
+incdir+logic
logic/ising_cfg_pkg.sv
logic/cfg_cmd_decode.sv
logic/step_counter.sv
logic/analog_cfg.sv
logic/cfg_data_mem.sv
logic/analog_shadow_array.sv
logic/ising_cfg_top.sv
sim/ising_cfg_tb.sv

// ==== Bender.yml ====
package:
  name: ising_cfg

export_include_dirs:
  - logic

sources:
  - logic/ising_cfg_pkg.sv
  - logic/cfg_cmd_decode.sv
  - logic/step_counter.sv
  - logic/analog_cfg.sv
  - logic/cfg_data_mem.sv
  - logic/analog_shadow_array.sv
  - logic/ising_cfg_top.sv
  - target: simulation
    files:
      - sim/ising_cfg_tb.sv
